/* verilog/rvPkg.sv */
package rvPkg;

localparam int XLEN = 32;

typedef enum logic [6:0] {
    rType    = 7'b0110011,
    iType    = 7'b0010011,
    sType    = 7'b0100011,
    bType    = 7'b1100011,
    uType    = 7'b0110111,
    jType    = 7'b1101111,
    loadType = 7'b0000011,
    jalrType = 7'b1100111
} opcodeT;

typedef enum logic [4:0] {
    fetch    = 5'b00000,
    decode   = 5'b00001,
    exI      = 5'b00010,
    exR      = 5'b00011,
    exB      = 5'b00100,
    exJ      = 5'b00101,
    jumpJalr = 5'b00110,
    exS      = 5'b00111,
    linkJ    = 5'b01000,
    exJalr   = 5'b01001,
    exLw     = 5'b01010,
    memLw    = 5'b01011,
    wbI      = 5'b01100,
    memS     = 5'b01101,
    wbR      = 5'b01110,
    wbU      = 5'b01111,
    jumpJ    = 5'b10000,
    wbLw     = 5'b10001
} ctrlStateT;

typedef enum logic [1:0] {aluAdd, aluBranch, aluRDecode, aluIDecode} aluOpT;
typedef enum logic [2:0] {fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt, fnSll, fnSrl} aluFuncT;
typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSelT;
typedef enum logic [1:0] {srcPc, srcOldPc, srcRegA} srcASelT;
typedef enum logic [1:0] {srcRegB, srcImm, srcFour} srcBSelT;
typedef enum logic [1:0] {resAluOut, resData, resAluDirect, resImm} resultSelT;

typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} rFmtT;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} iFmtT;

typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
} sFmtT;

typedef struct packed {
    logic       bit12;
    logic [5:0] bits10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] bits4to1;
    logic       bit11;
    logic [6:0] opcode;
} bFmtT;

typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} uFmtT;

typedef struct packed {
    logic       bit20;
    logic [9:0] bits10to1;
    logic       bit11;
    logic [7:0] bits19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
} jFmtT;

typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    sFmtT sFmt;
    bFmtT bFmt;
    uFmtT uFmt;
    jFmtT jFmt;
} instrT;

endpackage

/* verilog/ctrlIf.sv */
`timescale 1ns/1ns
interface ctrlIf
    import rvPkg::*;
(
    input logic clk,
    input logic rst
);

resultSelT resultSrc;
srcASelT aluSrcA;
srcBSelT aluSrcB;
aluOpT aluOp;
immSelT immSrc;
logic adrSrc;
logic regWrite;
logic memWrite;
logic pcUpdate;
logic branch;
logic irWrite;
opcodeT opcode;  // Sent back by the datapath.

modport ctrl(
    output resultSrc, aluSrcA, aluSrcB, aluOp, immSrc,
    output adrSrc, regWrite, memWrite, pcUpdate, branch, irWrite,
    input opcode
);

modport dp(
    input resultSrc, aluSrcA, aluSrcB, aluOp, immSrc,
    input adrSrc, regWrite, pcUpdate, branch, irWrite,
    output opcode
);

// A store and a register write never share a cycle.
assert property (@(posedge clk) disable iff (rst) !(memWrite && regWrite))
    else $error("memWrite and regWrite high in the same cycle");

endinterface

/* verilog/alu.sv */
`timescale 1ns/1ns
module alu
    import rvPkg::*;
(
    input aluOpT aluOp,
    input logic [2:0] funct3,
    input logic funct7b5,
    input logic opcodeB5,
    input logic [XLEN-1:0] srcA,
    input logic [XLEN-1:0] srcB,
    output logic [XLEN-1:0] result,
    output logic zero,
    output logic lessThan
);

aluFuncT func;
logic [XLEN-1:0] diff;
logic overflow;

assign diff = srcA - srcB;
assign overflow = (srcA[XLEN-1] ^ srcB[XLEN-1]) & (diff[XLEN-1] ^ srcA[XLEN-1]);
assign lessThan = diff[XLEN-1] ^ overflow;  // Signed compare.
assign zero = (result == '0);

always_comb begin
    case (aluOp)
        aluBranch: func = fnSub;
        aluRDecode, aluIDecode: begin
            case (funct3)
                3'b000: func = (funct7b5 && opcodeB5) ? fnSub : fnAdd;  // R-type only.
                3'b001: func = fnSll;
                3'b010: func = fnSlt;
                3'b100: func = fnXor;
                3'b101: func = fnSrl;
                3'b110: func = fnOr;
                3'b111: func = fnAnd;
                default: func = fnAdd;
            endcase
        end
        default: func = fnAdd;
    endcase
end

always_comb begin
    case (func)
        fnSub: result = diff;
        fnAnd: result = srcA & srcB;
        fnOr: result = srcA | srcB;
        fnXor: result = srcA ^ srcB;
        fnSlt: result = {{(XLEN-1){1'b0}}, lessThan};
        fnSll: result = srcA << srcB[4:0];
        fnSrl: result = srcA >> srcB[4:0];
        default: result = srcA + srcB;
    endcase
end

endmodule

/* verilog/immExtend.sv */
`timescale 1ns/1ns
module immExtend
    import rvPkg::*;
(
    input instrT instr,
    input immSelT immSrc,
    output logic [XLEN-1:0] imm
);

always_comb begin
    case (immSrc)
        immI: imm = {{(XLEN-12){instr.iFmt.imm[11]}}, instr.iFmt.imm};
        immS: imm = {{(XLEN-12){instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
        immB: imm = {{(XLEN-12){instr.bFmt.bit12}}, instr.bFmt.bit11,
                     instr.bFmt.bits10to5, instr.bFmt.bits4to1, 1'b0};
        immJ: imm = {{(XLEN-20){instr.jFmt.bit20}}, instr.jFmt.bits19to12,
                     instr.jFmt.bit11, instr.jFmt.bits10to1, 1'b0};
        immU: imm = {instr.uFmt.imm, 12'b0};  // Upper 20 bits.
        default: imm = '0;
    endcase
end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ns
module regFile
    import rvPkg::*;
(
    input logic clk,
    input logic rst,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    input logic [4:0] rd,
    input logic writeEn,
    input logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readA,
    output logic [XLEN-1:0] readB
);

logic [XLEN-1:0] regs [32];

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (writeEn && rd != 5'd0) begin  // x0 stays zero.
        regs[rd] <= writeData;
    end
end

assign readA = regs[rs1];
assign readB = regs[rs2];

assert property (@(posedge clk) disable iff (rst) rs1 == 5'd0 |-> readA == '0)
    else $error("x0 read back nonzero");

endmodule

/* verilog/mainController.sv */
`timescale 1ns/1ns
module mainController
    import rvPkg::*;
(
    input logic clk,
    input logic rst,
    ctrlIf.ctrl ctrl
);

ctrlStateT state;
ctrlStateT nextState;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state <= fetch;
    end else begin
        state <= nextState;
    end
end

always_comb begin
    case (state)
        fetch: nextState = decode;
        decode: begin
            case (ctrl.opcode)
                iType: nextState = exI;
                rType: nextState = exR;
                bType: nextState = exB;
                jType: nextState = exJ;
                uType: nextState = wbU;
                sType: nextState = exS;
                jalrType: nextState = exJalr;
                loadType: nextState = exLw;
                default: nextState = fetch;  // Unknown opcode.
            endcase
        end
        exI: nextState = wbI;
        exR: nextState = wbR;
        exJ: nextState = linkJ;
        linkJ: nextState = jumpJ;
        exJalr: nextState = jumpJalr;
        jumpJalr: nextState = wbI;  // Link written by wbI.
        exS: nextState = memS;
        exLw: nextState = memLw;
        memLw: nextState = wbLw;
        default: nextState = fetch;
    endcase
end

always_comb begin
    ctrl.resultSrc = resAluOut;
    ctrl.aluSrcA = srcPc;
    ctrl.aluSrcB = srcRegB;
    ctrl.aluOp = aluAdd;
    ctrl.immSrc = immI;
    ctrl.adrSrc = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.pcUpdate = 1'b0;
    ctrl.branch = 1'b0;
    ctrl.irWrite = 1'b0;
    case (state)
        fetch: begin
            ctrl.irWrite = 1'b1;
            ctrl.aluSrcB = srcFour;
            ctrl.resultSrc = resAluDirect;  // PC plus four.
            ctrl.pcUpdate = 1'b1;
        end
        decode: begin
            ctrl.aluSrcA = srcOldPc;  // Branch target into aluOut.
            ctrl.aluSrcB = srcImm;
            ctrl.immSrc = immB;
        end
        exI: begin
            ctrl.aluSrcA = srcRegA;
            ctrl.aluSrcB = srcImm;
            ctrl.aluOp = aluIDecode;
        end
        exLw, exJalr: begin
            ctrl.aluSrcA = srcRegA;
            ctrl.aluSrcB = srcImm;
        end
        exS: begin
            ctrl.aluSrcA = srcRegA;
            ctrl.aluSrcB = srcImm;
            ctrl.immSrc = immS;
        end
        exR: begin
            ctrl.aluSrcA = srcRegA;
            ctrl.aluOp = aluRDecode;
        end
        exB: begin
            ctrl.aluSrcA = srcRegA;
            ctrl.aluOp = aluBranch;
            ctrl.branch = 1'b1;
        end
        exJ: begin
            ctrl.aluSrcA = srcOldPc;
            ctrl.aluSrcB = srcFour;
        end
        linkJ: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcA = srcOldPc;  // Jump target computed alongside the link.
            ctrl.aluSrcB = srcImm;
            ctrl.immSrc = immJ;
        end
        jumpJalr: begin
            ctrl.aluSrcA = srcOldPc;
            ctrl.aluSrcB = srcFour;
            ctrl.pcUpdate = 1'b1;
        end
        jumpJ: ctrl.pcUpdate = 1'b1;
        memS: begin
            ctrl.adrSrc = 1'b1;
            ctrl.memWrite = 1'b1;
        end
        memLw: ctrl.adrSrc = 1'b1;
        wbLw: begin
            ctrl.resultSrc = resData;
            ctrl.regWrite = 1'b1;
        end
        wbU: begin
            ctrl.resultSrc = resImm;
            ctrl.immSrc = immU;
            ctrl.regWrite = 1'b1;
        end
        wbI, wbR: ctrl.regWrite = 1'b1;
        default: ;
    endcase
end

assert property (@(posedge clk) disable iff (rst) ctrl.irWrite |-> state == fetch)
    else $error("irWrite outside fetch");

assert property (@(posedge clk) disable iff (rst)
    state inside {fetch, decode, exI, wbI, exR, wbR, exB, exJ, linkJ, jumpJ,
                  exJalr, jumpJalr, exS, memS, exLw, memLw, wbLw, wbU})
    else $error("illegal controller state");

assert property (@(posedge clk) disable iff (rst) state == memLw |=> state == wbLw)
    else $error("load did not reach write-back");

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ns
module datapath
    import rvPkg::*;
#(
    parameter logic [XLEN-1:0] resetAddr = '0
) (
    input logic clk,
    input logic rst,
    ctrlIf.dp dp,
    input logic [XLEN-1:0] memRData,
    output logic [XLEN-1:0] memAddr,
    output logic [XLEN-1:0] memWData
);

logic [XLEN-1:0] pc;
logic [XLEN-1:0] oldPc;
instrT instr;
logic [XLEN-1:0] dataReg;
logic [XLEN-1:0] regA;
logic [XLEN-1:0] regB;
logic [XLEN-1:0] aluOut;
logic [XLEN-1:0] rfA;
logic [XLEN-1:0] rfB;
logic [XLEN-1:0] imm;
logic [XLEN-1:0] srcA;
logic [XLEN-1:0] srcB;
logic [XLEN-1:0] aluResult;
logic [XLEN-1:0] result;
logic zero;
logic lessThan;
logic takeBranch;
logic pcEn;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pc <= resetAddr;
    end else if (pcEn) begin
        pc <= result;
    end
end

always_ff @(posedge clk) begin
    if (dp.irWrite) begin
        instr <= memRData;
        oldPc <= pc;  // Address of the fetched instruction.
    end
    dataReg <= memRData;
    regA <= rfA;
    regB <= rfB;
    aluOut <= aluResult;
end

always_comb begin
    case (dp.aluSrcA)
        srcPc: srcA = pc;
        srcOldPc: srcA = oldPc;
        default: srcA = regA;
    endcase
    case (dp.aluSrcB)
        srcRegB: srcB = regB;
        srcImm: srcB = imm;
        default: srcB = XLEN'(4);
    endcase
    case (dp.resultSrc)
        resAluOut: result = aluOut;
        resData: result = dataReg;
        resAluDirect: result = aluResult;
        default: result = imm;
    endcase
end

always_comb begin
    case (instr.bFmt.funct3)
        3'b000: takeBranch = zero;
        3'b001: takeBranch = !zero;
        3'b100: takeBranch = lessThan;
        3'b101: takeBranch = !lessThan;
        default: takeBranch = 1'b0;
    endcase
end

assign pcEn = dp.pcUpdate || (dp.branch && takeBranch);
assign memAddr = dp.adrSrc ? result : pc;
assign memWData = regB;
assign dp.opcode = opcodeT'(instr.rFmt.opcode);

regFile rf(
    .clk(clk),
    .rst(rst),
    .rs1(instr.rFmt.rs1),
    .rs2(instr.rFmt.rs2),
    .rd(instr.rFmt.rd),
    .writeEn(dp.regWrite),
    .writeData(result),
    .readA(rfA),
    .readB(rfB)
);

immExtend ext(.instr(instr), .immSrc(dp.immSrc), .imm(imm));

alu aluUnit(
    .aluOp(dp.aluOp),
    .funct3(instr.rFmt.funct3),
    .funct7b5(instr.rFmt.funct7[5]),
    .opcodeB5(instr.rFmt.opcode[5]),
    .srcA(srcA),
    .srcB(srcB),
    .result(aluResult),
    .zero(zero),
    .lessThan(lessThan)
);

endmodule

/* verilog/multiCycleCpu.sv */
`timescale 1ns/1ns
module multiCycleCpu
    import rvPkg::*;
#(
    parameter logic [XLEN-1:0] resetAddr = '0
) (
    input logic clk,
    input logic rst,
    input logic [31:0] memRData,
    output logic [31:0] memAddr,
    output logic [31:0] memWData,
    output logic memWrite
);

ctrlIf ctrlBus(.clk(clk), .rst(rst));

mainController controller(
    .clk(clk),
    .rst(rst),
    .ctrl(ctrlBus.ctrl)
);

datapath #(
    .resetAddr(resetAddr)
) dpath(
    .clk(clk),
    .rst(rst),
    .dp(ctrlBus.dp),
    .memRData(memRData),
    .memAddr(memAddr),
    .memWData(memWData)
);

assign memWrite = ctrlBus.memWrite;  // Straight from the controller.

endmodule

/* tests/cpuTb.sv */
`timescale 1ns/1ns
module cpuTb;

localparam int memWords = 256;
localparam int waitLimit = 1000;  // Cycles allowed per test.
localparam logic [31:0] dataBase = 32'h300;
localparam logic [31:0] preloadAddr = 32'h3f0;
localparam logic [31:0] poisonAddr = 32'h3fc;
localparam logic [6:0] opR = 7'b0110011;
localparam logic [6:0] opImm = 7'b0010011;
localparam logic [6:0] opLoad = 7'b0000011;
localparam logic [6:0] opStore = 7'b0100011;
localparam logic [6:0] opBranch = 7'b1100011;
localparam logic [6:0] opJal = 7'b1101111;
localparam logic [6:0] opJalr = 7'b1100111;
localparam logic [6:0] opLui = 7'b0110111;

logic clk = 1'b0;
logic rst = 1'b1;
logic [31:0] memRData;
logic [31:0] memAddr;
logic [31:0] memWData;
logic memWrite;

logic [31:0] mem [memWords];
logic [31:0] image [memWords];  // Copied into mem while in reset.
logic [31:0] model [32];        // Register file as the ISA defines it.
logic [31:0] expAddr [64];
logic [31:0] expData [64];
int expCount = 0;
int storeIdx = 0;
int errorCount = 0;
int passCount = 0;
int failCount = 0;
int testLast [6];
string testName [6];
logic [15:0] lfsr;
logic [31:0] progPc;
int slot;

multiCycleCpu dut(
    .clk(clk),
    .rst(rst),
    .memRData(memRData),
    .memAddr(memAddr),
    .memWData(memWData),
    .memWrite(memWrite)
);

always #10 clk = ~clk;

always @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] <= image[i];
        end
    end else if (memWrite) begin
        mem[memAddr[9:2]] <= memWData;
    end
end

assign memRData = mem[memAddr[9:2]];

always @(posedge clk) begin
    if (rst) begin
        storeIdx <= 0;
    end else if (memWrite) begin
        storeIdx <= storeIdx + 1;
    end
end

// Checked at the falling edge, where the store is stable.
assert property (@(negedge clk) rst |-> !memWrite)
    else begin
        errorCount++;
        $display("mismatch memWrite during reset: expected 0x0, got 0x%h", memWrite);
    end

assert property (@(negedge clk) $fell(rst) |-> memAddr == 32'h0)
    else begin
        errorCount++;
        $display("mismatch memAddr after reset: expected 0x00000000, got 0x%h", memAddr);
    end

assert property (@(negedge clk) disable iff (rst) memWrite |-> storeIdx < expCount)
    else begin
        errorCount++;
        $display("unexpected store number %0d to address 0x%h", storeIdx, memAddr);
    end

assert property (@(negedge clk) disable iff (rst)
    (memWrite && storeIdx < expCount) |-> memAddr == expAddr[storeIdx])
    else begin
        errorCount++;
        $display("mismatch memAddr at store %0d: expected 0x%h, got 0x%h",
                 storeIdx, expAddr[storeIdx], memAddr);
    end

assert property (@(negedge clk) disable iff (rst)
    (memWrite && storeIdx < expCount) |-> memWData == expData[storeIdx])
    else begin
        errorCount++;
        $display("mismatch memWData at store %0d: expected 0x%h, got 0x%h",
                 storeIdx, expData[storeIdx], memWData);
    end

function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr[15]};
        lfsr = lfsrStep(lfsr);
    end
    return v;
endfunction

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic isSub,
        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000: return isSub ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100: return a ^ b;
        3'b101: return a >> b[4:0];
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        default: return $signed(a) >= $signed(b);
    endcase
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

task automatic emit(input logic [31:0] word);
    image[progPc[9:2]] = word;
    progPc = progPc + 32'd4;
endtask

task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
        model[rd] = value;
    end
endtask

task automatic aluReg(input logic [2:0] f3, input logic isSub, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2);
    emit({isSub ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opR});
    setReg(rd, aluRef(f3, isSub, model[rs1], model[rs2]));
endtask

task automatic aluImm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
    emit(encI(imm, rs1, f3, rd, opImm));
    setReg(rd, aluRef(f3, 1'b0, model[rs1], sext12(imm)));
endtask

task automatic storeWord(input logic [4:0] rs2, input logic [31:0] addr);
    emit(encS(addr[11:0], rs2, 5'd0));  // Base is x0.
endtask

task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr[expCount] = addr;
    expData[expCount] = data;
    expCount++;
endtask

task automatic storeChecked(input logic [4:0] rs2);
    logic [31:0] addr;
    addr = dataBase + 32'(slot * 4);
    storeWord(rs2, addr);
    expectStore(addr, model[rs2]);
    slot++;
endtask

task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [11:0] mark);
    logic taken;
    taken = branchTaken(f3, model[rs1], model[rs2]);
    emit(encB(13'd8, rs2, rs1, f3));
    storeWord(5'd20, poisonAddr);  // Skipped when taken.
    if (!taken) begin
        expectStore(poisonAddr, model[20]);
    end
    aluImm(3'b000, 5'd8, 5'd0, mark);
    storeChecked(5'd8);
endtask

task automatic buildProgram();
    logic [31:0] r;
    logic [31:0] pcHere;
    logic [2:0] rOps [8];
    logic [2:0] iOps [7];
    rOps = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
    iOps = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
    lfsr = 16'd9;
    progPc = '0;
    slot = 0;
    for (int i = 0; i < memWords; i++) begin
        image[i] = 32'hdead_0000 ^ (32'(i) << 8);  // Zero opcode field decodes as unknown.
    end
    for (int i = 0; i < 32; i++) begin
        model[i] = '0;
    end
    testName = '{"reset", "alu", "load", "branch", "jump", "lui"};
    r = randBits(20);
    emit({r[19:0], 5'd1, opLui});  // Upper bits keep x1 away from zero.
    setReg(5'd1, {r[19:0], 12'h000});
    r = randBits(12);
    aluImm(3'b000, 5'd1, 5'd1, r[11:0]);
    r = randBits(12);
    aluImm(3'b000, 5'd2, 5'd0, r[11:0]);
    for (int k = 0; k < 8; k++) begin
        aluReg(rOps[k], k == 1, 5'd3, 5'd2, 5'd1);  // Second entry is sub.
        storeChecked(5'd3);
    end
    for (int k = 0; k < 7; k++) begin
        r = (iOps[k] == 3'b001 || iOps[k] == 3'b101) ? randBits(5) : randBits(12);
        aluImm(iOps[k], 5'd3, 5'd1, r[11:0]);
        storeChecked(5'd3);
    end
    testLast[1] = expCount;
    r = randBits(32);
    image[preloadAddr[9:2]] = r;
    aluImm(3'b000, 5'd5, 5'd0, 12'h3e0);
    emit(encI(12'd16, 5'd5, 3'b010, 5'd6, opLoad));
    setReg(5'd6, r);
    r = randBits(12);
    aluImm(3'b000, 5'd6, 5'd6, r[11:0]);
    storeChecked(5'd6);
    testLast[2] = expCount;
    aluImm(3'b000, 5'd9, 5'd1, 12'd1);  // x9 is one above x1.
    aluImm(3'b000, 5'd20, 5'd0, 12'h5ad);
    branchCase(3'b000, 5'd1, 5'd1, 12'd1);
    branchCase(3'b000, 5'd1, 5'd9, 12'd2);
    branchCase(3'b001, 5'd1, 5'd9, 12'd3);
    branchCase(3'b001, 5'd1, 5'd1, 12'd4);
    branchCase(3'b100, 5'd1, 5'd9, 12'd5);
    branchCase(3'b100, 5'd9, 5'd1, 12'd6);
    branchCase(3'b101, 5'd9, 5'd1, 12'd7);
    branchCase(3'b101, 5'd1, 5'd9, 12'd8);
    testLast[3] = expCount;
    pcHere = progPc;
    emit(encJ(21'd12, 5'd12));
    setReg(5'd12, pcHere + 32'd4);
    storeWord(5'd20, poisonAddr);
    storeWord(5'd20, poisonAddr);
    storeChecked(5'd12);
    aluImm(3'b000, 5'd13, 5'd0, progPc[11:0] + 12'd12);  // Lands past one poison store.
    pcHere = progPc;
    emit(encI(12'd0, 5'd13, 3'b000, 5'd14, opJalr));
    setReg(5'd14, pcHere + 32'd4);
    storeWord(5'd20, poisonAddr);
    storeChecked(5'd14);
    testLast[4] = expCount;
    r = randBits(20);
    emit({r[19:0], 5'd15, opLui});
    setReg(5'd15, {r[19:0], 12'h000});
    r = randBits(12);
    aluImm(3'b000, 5'd15, 5'd15, r[11:0]);
    storeChecked(5'd15);
    testLast[5] = expCount;
    emit(encJ(21'd0, 5'd0));  // Self loop.
endtask

task automatic reportTest(input string name, input int errs, input logic hung);
    if (errs == 0 && !hung) begin
        passCount++;
        $display("test %s: passed", name);
    end else begin
        failCount++;
        $display("test %s: failed with %0d errors", name, errs);
    end
endtask

initial begin
    int errBefore;
    int cycles;
    logic timedOut;
    timedOut = 1'b0;
    buildProgram();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    reportTest(testName[0], errorCount, 1'b0);
    for (int t = 1; t < 6; t++) begin
        errBefore = errorCount;
        cycles = 0;
        while (!timedOut && storeIdx < testLast[t]) begin
            @(negedge clk);
            cycles++;
            if (cycles >= waitLimit) begin
                timedOut = 1'b1;
                $display("timeout: program did not reach its final store in test %s",
                         testName[t]);
            end
        end
        if (t == 5) begin
            repeat (20) @(negedge clk);  // Catches a stray store after the last one.
        end
        reportTest(testName[t], errorCount - errBefore, timedOut);
    end
    $display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
             errorCount);
    if (failCount == 0 && errorCount == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

/* files.f */
verilog/rvPkg.sv
verilog/ctrlIf.sv
verilog/alu.sv
verilog/immExtend.sv
verilog/regFile.sv
verilog/mainController.sv
verilog/datapath.sv
verilog/multiCycleCpu.sv
tests/cpuTb.sv

/* run.sh */
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f files.f --top-module cpuTb -o cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
